// ==== include/ch2_defines.svh ====
`ifndef CH2_DEFINES_SVH
`define CH2_DEFINES_SVH

// register index on the 2-bit address
`define CH2_NR21 2'd0
`define CH2_NR22 2'd1
`define CH2_NR23 2'd2
`define CH2_NR24 2'd3

// bits that cannot be read come back as ones
`define CH2_NR21_RMASK 8'h3F
`define CH2_NR23_RMASK 8'hFF
`define CH2_NR24_RMASK 8'hBF

`define CH2_FREQ_W   11
`define CH2_LEN_W    6
`define CH2_LEN_FULL 64

`endif

// ==== verilog/apu_reg_pkg.sv ====
`default_nettype none

`include "ch2_defines.svh"

package apu_reg_pkg;

	typedef struct packed {
		logic [1:0]            duty;
		logic [`CH2_LEN_W-1:0] len_load;    // write only
	} nr21_t;

	typedef struct packed {
		logic [3:0] init_vol;
		logic       env_inc;                 // 1 = louder
		logic [2:0] env_period;
	} nr22_t;

	typedef struct packed {
		logic       trigger;
		logic       len_en;
		logic [2:0] unused;
		logic [2:0] freq_hi;
	} nr24_t;

	typedef struct packed {
		nr21_t      nr21;
		nr22_t      nr22;
		logic [7:0] nr23;                    // frequency low byte
		nr24_t      nr24;
	} ch2_regs_t;

endpackage

`default_nettype wire

// ==== verilog/ch2_pkg.sv ====
`default_nettype none

`include "ch2_defines.svh"

package ch2_pkg;

	typedef struct packed {
		logic length_tick;
		logic env_tick;
	} seq_ticks_t;

	typedef struct packed {
		logic                   trigger;     // one-cycle pulse
		logic                   len_wr;      // NR21 was written
		logic [`CH2_LEN_W-1:0]  len_load;
		logic                   len_en;
		logic                   dac_on;
		logic [3:0]             env_vol;
		logic                   env_inc;
		logic [2:0]             env_period;
		logic [1:0]             duty;
		logic [`CH2_FREQ_W-1:0] freq;
	} ch2_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/apu_frame_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module apu_frame_seq
	import ch2_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       div_tick,
	output seq_ticks_t ticks
);

	logic [2:0] step;

	always_ff @(posedge clk) begin
		if (reset) begin
			step  <= 3'd0;
			ticks <= '0;
		end else begin
			if (div_tick) begin
				ticks.length_tick <= ~step[0];          // steps 0, 2, 4, 6
				ticks.env_tick    <= (step == 3'd7);
				step              <= step + 3'd1;
			end else begin
				ticks <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ch2_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ch2_defines.svh"

module ch2_regs
	import apu_reg_pkg::*;
	import ch2_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       wr,
	input  logic [1:0] addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output ch2_ctrl_t  ctrl
);

	ch2_regs_t regs;
	logic      trigger;
	logic      len_wr;

	always_ff @(posedge clk) begin
		if (reset) begin
			regs    <= '0;
			trigger <= 1'b0;
			len_wr  <= 1'b0;
		end else begin
			trigger <= wr && (addr == `CH2_NR24) && wdata[7];
			len_wr  <= wr && (addr == `CH2_NR21);
			if (wr) begin
				case (addr)
					`CH2_NR21: regs.nr21 <= nr21_t'(wdata);
					`CH2_NR22: regs.nr22 <= nr22_t'(wdata);
					`CH2_NR23: regs.nr23 <= wdata;
					`CH2_NR24: regs.nr24 <= nr24_t'({1'b0, wdata[6:0]});   // trigger is never held
					default:   regs      <= regs;
				endcase
			end
		end
	end

	always_comb begin
		case (addr)
			`CH2_NR21: rdata = regs.nr21 | `CH2_NR21_RMASK;
			`CH2_NR22: rdata = regs.nr22;
			`CH2_NR23: rdata = regs.nr23 | `CH2_NR23_RMASK;
			default:   rdata = regs.nr24 | `CH2_NR24_RMASK;
		endcase
	end

	// dac is off when volume and direction are all zero
	assign ctrl.dac_on = |regs.nr22[7:3];

	assign ctrl.trigger    = trigger;
	assign ctrl.len_wr     = len_wr;
	assign ctrl.len_load   = regs.nr21.len_load;
	assign ctrl.len_en     = regs.nr24.len_en;
	assign ctrl.env_vol    = regs.nr22.init_vol;
	assign ctrl.env_inc    = regs.nr22.env_inc;
	assign ctrl.env_period = regs.nr22.env_period;
	assign ctrl.duty       = regs.nr21.duty;
	assign ctrl.freq       = {regs.nr24.freq_hi, regs.nr23};

endmodule

`default_nettype wire

// ==== verilog/ch2_length.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ch2_defines.svh"

module ch2_length
	import ch2_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  ch2_ctrl_t  ctrl,
	input  seq_ticks_t ticks,
	output logic       len_active
);

	localparam logic [`CH2_LEN_W:0] LEN_FULL = `CH2_LEN_FULL;

	logic [`CH2_LEN_W:0] count;                 // one extra bit to hold 64
	logic                dec;

	assign dec = ticks.length_tick && ctrl.len_en && (count != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			count      <= '0;
			len_active <= 1'b0;
		end else begin
			if (ctrl.len_wr)
				count <= LEN_FULL - {1'b0, ctrl.len_load};
			else if (ctrl.trigger && count == '0)
				count <= LEN_FULL;
			else if (dec)
				count <= count - 1'b1;

			if (!ctrl.dac_on)
				len_active <= 1'b0;
			else if (ctrl.trigger)
				len_active <= 1'b1;
			else if (dec && count == 1)
				len_active <= 1'b0;             // expired
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ch2_envelope.sv ====
`timescale 1ns/1ns
`default_nettype none

module ch2_envelope
	import ch2_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  ch2_ctrl_t  ctrl,
	input  seq_ticks_t ticks,
	output logic [3:0] volume
);

	logic [2:0] period_cnt;
	logic       expire;

	assign expire = (period_cnt <= 3'd1);

	always_ff @(posedge clk) begin
		if (reset) begin
			volume     <= 4'd0;
			period_cnt <= 3'd0;
		end else if (ctrl.trigger) begin
			volume     <= ctrl.env_vol;
			period_cnt <= ctrl.env_period;
		end else if (ticks.env_tick && ctrl.env_period != 3'd0) begin
			if (expire) begin
				period_cnt <= ctrl.env_period;
				if (ctrl.env_inc) begin
					if (volume != 4'd15)
						volume <= volume + 4'd1;
				end else begin
					if (volume != 4'd0)
						volume <= volume - 4'd1;
				end
			end else begin
				period_cnt <= period_cnt - 3'd1;
			end
		end
	end

	// period zero leaves volume where it is

endmodule

`default_nettype wire

// ==== verilog/ch2_wave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ch2_defines.svh"

module ch2_wave
	import ch2_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  ch2_ctrl_t ctrl,
	output logic      wave_bit
);

	logic [`CH2_FREQ_W-1:0] timer;
	logic [`CH2_FREQ_W-1:0] reload;
	logic [2:0]             step;
	logic [7:0]             pattern;

	// timer counts down to zero inclusive
	// so a reload of 2047 - freq gives a period of 2048 - freq
	assign reload = ~ctrl.freq;

	always_ff @(posedge clk) begin
		if (reset) begin
			timer <= '0;
			step  <= 3'd0;
		end else if (ctrl.trigger) begin
			timer <= reload;
			step  <= 3'd0;
		end else if (timer == '0) begin
			timer <= reload;
			step  <= step + 3'd1;
		end else begin
			timer <= timer - 1'b1;
		end
	end

	always_comb begin
		case (ctrl.duty)
			2'd0:    pattern = 8'b0000_0001;   // 12.5%
			2'd1:    pattern = 8'b1000_0001;
			2'd2:    pattern = 8'b1000_0111;
			default: pattern = 8'b0111_1110;   // 75%
		endcase
	end

	assign wave_bit = pattern[step];

endmodule

`default_nettype wire

// ==== verilog/ch2_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ch2_top
	import ch2_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       wr,
	input  logic [1:0] addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	input  logic       div_tick,
	output logic [3:0] sample,
	output logic       active
);

	seq_ticks_t ticks;
	ch2_ctrl_t  ctrl;
	logic       len_active;
	logic [3:0] volume;
	logic       wave_bit;

	apu_frame_seq u_seq (
		.clk, .reset, .div_tick, .ticks
	);

	ch2_regs u_regs (
		.clk, .reset, .wr, .addr, .wdata, .rdata, .ctrl
	);

	ch2_length u_length (
		.clk, .reset, .ctrl, .ticks, .len_active
	);

	ch2_envelope u_env (
		.clk, .reset, .ctrl, .ticks, .volume
	);

	ch2_wave u_wave (
		.clk, .reset, .ctrl, .wave_bit
	);

	assign active = len_active && ctrl.dac_on;
	assign sample = (active && wave_bit) ? volume : 4'd0;   // silent in the low phase

endmodule

`default_nettype wire

// ==== bench/ch2_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ch2_defines.svh"

module ch2_sva (
	input logic       clk,
	input logic       reset,
	input logic [1:0] addr,
	input logic [7:0] rdata,
	input logic [3:0] sample,
	input logic       active
);

	int unsigned error_count = 0;

	assert property (@(posedge clk) reset |=> (!active && sample == 4'd0))
	else begin
		error_count++;
		$error("channel output not idle while in reset");
	end

	assert property (@(posedge clk) disable iff (reset) !active |-> sample == 4'd0)
	else begin
		error_count++;
		$error("sample nonzero on an inactive channel");
	end

	assert property (@(posedge clk) disable iff (reset) addr == `CH2_NR23 |-> rdata == 8'hFF)
	else begin
		error_count++;
		$error("frequency low byte readable");
	end

endmodule

bind ch2_top ch2_sva u_sva (.*);

`default_nettype wire

// ==== bench/ch2_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ch2_defines.svh"

module ch2_tb;

	logic        clk;
	logic        reset;
	logic        wr;
	logic [1:0]  addr;
	logic [7:0]  wdata;
	logic [7:0]  rdata;
	logic        div_tick;
	logic [3:0]  sample;
	logic        active;
	logic [31:0] lfsr;
	int          seq_step;                  // sequencer step, counted since reset

	ch2_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// unreadable bits come back set
	function automatic logic [7:0] read_mask(input int r);
		logic [7:0] masks [4];
		masks = '{8'h3F, 8'h00, 8'hFF, 8'hBF};
		return masks[r];
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_equal(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected)
		else begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic stop_with_error(input string what);
		$display("timeout: %s", what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic write_reg(input logic [1:0] a, input logic [7:0] d);
		@(posedge clk);
		#1;
		wr = 1'b1;
		addr = a;
		wdata = d;
		@(posedge clk);
		#1;
		wr = 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] a, output logic [7:0] d);
		@(posedge clk);
		#1;
		addr = a;
		#1;
		d = rdata;
	endtask

	// returns one cycle after the trigger pulse has been applied
	task automatic trigger_channel(input logic len_en, input logic [2:0] freq_hi);
		write_reg(`CH2_NR24, {1'b1, len_en, 3'b000, freq_hi});
		@(posedge clk);
		#1;
	endtask

	task automatic pulse_div(output logic was_len, output logic was_env);
		was_len = (seq_step % 2 == 0);
		was_env = (seq_step == 7);
		seq_step = (seq_step + 1) % 8;
		@(posedge clk);
		#1;
		div_tick = 1'b1;
		@(posedge clk);
		#1;
		div_tick = 1'b0;
		@(posedge clk);                         // tick reaches the counters here
		#1;
	endtask

	// one full duty cycle at a period of 32 clocks per step
	task automatic peak_sample(output logic [3:0] peak);
		peak = 4'd0;
		for (int i = 0; i < 8 * 32; i++) begin
			@(posedge clk);
			#1;
			if (sample > peak)
				peak = sample;
		end
	endtask

	task automatic test_reset_state();
		logic [7:0] got;
		check_equal("reset_active", 0, active);
		check_equal("reset_sample", 0, sample);
		for (int r = 0; r < 4; r++) begin
			read_reg(r[1:0], got);
			check_equal("reset_regs", read_mask(r), got);
		end
	endtask

	task automatic test_readback();
		logic [7:0] data [4];
		logic [7:0] got;
		for (int r = 0; r < 4; r++) begin
			random_byte(data[r]);
			write_reg(r[1:0], data[r]);
		end
		for (int r = 0; r < 4; r++) begin
			read_reg(r[1:0], got);
			check_equal("readback", data[r] | read_mask(r), got);
		end
	endtask

	task automatic test_duty();
		int ones [4];
		int highs;
		ones = '{1, 2, 4, 6};
		for (int d = 0; d < 4; d++) begin
			write_reg(`CH2_NR21, {d[1:0], 6'd0});
			write_reg(`CH2_NR22, 8'hF0);        // volume 15, envelope frozen
			write_reg(`CH2_NR23, 8'hE0);        // frequency 2016
			trigger_channel(1'b0, 3'd7);
			highs = 0;
			for (int i = 0; i < 8 * 32; i++) begin
				if (sample == 4'd15)
					highs++;
				@(posedge clk);
				#1;
			end
			check_equal("duty", 32 * ones[d], highs);
		end
	endtask

	task automatic test_length();
		logic [7:0] rnd;
		logic [5:0] len;
		int         need;
		int         seen;
		int         pulses;
		logic       was_len;
		logic       was_env;
		random_byte(rnd);
		len = 6'd56 + {3'd0, rnd[2:0]};
		need = 64 - len;
		write_reg(`CH2_NR21, {2'd2, len});
		write_reg(`CH2_NR22, 8'hF0);
		trigger_channel(1'b1, 3'd7);
		seen = 0;
		pulses = 0;
		while (seen < need && pulses < 100) begin
			pulse_div(was_len, was_env);
			pulses++;
			if (was_len)
				seen++;
			if (seen < need)
				check_equal("length_hold", 1, active);
		end
		if (seen < need)
			stop_with_error("length ticks never reached the loaded length");
		check_equal("length_expiry", 0, active);
	endtask

	task automatic test_length_disabled();
		logic was_len;
		logic was_env;
		write_reg(`CH2_NR21, {2'd2, 6'd62});
		write_reg(`CH2_NR22, 8'hF0);
		trigger_channel(1'b0, 3'd7);
		for (int i = 0; i < 20; i++) begin
			pulse_div(was_len, was_env);
			check_equal("length_disabled", 1, active);
		end
	endtask

	task automatic test_envelope();
		int         vol;
		int         pulses;
		logic [3:0] peak;
		logic       was_len;
		logic       was_env;
		write_reg(`CH2_NR21, 8'hC0);            // duty 3
		write_reg(`CH2_NR22, 8'h59);            // volume 5, louder, period 1
		write_reg(`CH2_NR23, 8'hE0);
		trigger_channel(1'b0, 3'd7);
		vol = 5;
		peak_sample(peak);
		check_equal("envelope_start", vol, peak);
		for (int k = 0; k < 12; k++) begin
			was_env = 1'b0;
			pulses = 0;
			while (!was_env && pulses < 16) begin
				pulse_div(was_len, was_env);
				pulses++;
			end
			if (!was_env)
				stop_with_error("no envelope tick within 16 sequencer pulses");
			if (vol < 15)
				vol++;
			peak_sample(peak);
			check_equal("envelope_step", vol, peak);
		end
	endtask

	task automatic test_dac_off();
		write_reg(`CH2_NR22, 8'h07);            // upper five bits zero
		trigger_channel(1'b0, 3'd7);
		for (int i = 0; i < 64; i++) begin
			check_equal("dac_off_active", 0, active);
			check_equal("dac_off_sample", 0, sample);
			@(posedge clk);
			#1;
		end
		write_reg(`CH2_NR22, 8'hF0);
		check_equal("dac_on_idle", 0, active);  // channel stays off until a new trigger
		trigger_channel(1'b0, 3'd7);
		check_equal("dac_on_active", 1, active);
		write_reg(`CH2_NR22, 8'h00);
		check_equal("dac_cleared_active", 0, active);
		check_equal("dac_cleared_sample", 0, sample);
	endtask

	initial begin
		reset = 1'b1;
		wr = 1'b0;
		addr = 2'd0;
		wdata = 8'd0;
		div_tick = 1'b0;
		lfsr = 32'h4ac1_70fc;
		seq_step = 0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_readback();
		test_duty();
		test_length();
		test_length_disabled();
		test_envelope();
		test_dac_off();
		if (DUT.u_sva.error_count != 0) begin
			$display("TEST FAIL");
			$fatal(1, "bound assertions reported errors");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
verilog/apu_reg_pkg.sv
verilog/ch2_pkg.sv
verilog/apu_frame_seq.sv
verilog/ch2_regs.sv
verilog/ch2_length.sv
verilog/ch2_envelope.sv
verilog/ch2_wave.sv
verilog/ch2_top.sv
bench/ch2_sva.sv
bench/ch2_tb.sv
